/* design/aluPkg.sv */
// ====================
// ALU lane package: datapath widths, operation codes,
// index field positions, width modes, result word union
// ====================

package aluPkg;

	parameter int WordWidth = 64;
	parameter int LaneWidth = 32;
	parameter int IxtWidth = 6;

	// operation field, low four bits of the index
	localparam logic [3:0] OpAdd = 4'd0;
	localparam logic [3:0] OpSub = 4'd1;
	localparam logic [3:0] OpAdc = 4'd2;
	localparam logic [3:0] OpSbb = 4'd3;
	localparam logic [3:0] OpAnd = 4'd5;
	localparam logic [3:0] OpOr = 4'd6;
	localparam logic [3:0] OpXor = 4'd7;
	localparam logic [3:0] OpCselt = 4'd15;

	// index bits above the opcode
	localparam int IxtQword = 5;
	localparam int IxtZext = 4;

	// logic unit selector
	localparam logic [1:0] LogicAnd = 2'd0;
	localparam logic [1:0] LogicOr = 2'd1;
	localparam logic [1:0] LogicXor = 2'd2;
	localparam logic [1:0] LogicCsel = 2'd3;

	// width mode, same order as {qword, zext}
	localparam logic [1:0] Width32s = 2'b00;
	localparam logic [1:0] Width32u = 2'b01;
	localparam logic [1:0] Width64 = 2'b10;
	localparam logic [1:0] WidthPacked = 2'b11;

	// result word, whole qword or two dword lanes (lane[0] is low)
	typedef union packed {
		logic [WordWidth-1:0] full;
		logic [WordWidth/LaneWidth-1:0][LaneWidth-1:0] lane;
	} aluWord_t;

endpackage

/* design/aluDecode.sv */
// ====================
// ALU index decoder for adder, logic
// and result stage controls
// ====================

module aluDecode (
	input logic [aluPkg::IxtWidth-1:0] opIxt,
	input logic [1:0] srIn,
	output logic adderInvert,
	output logic carryLo,
	output logic carryHi,
	output logic splitLanes,
	output logic useAdder,
	output logic flagFromCarry,
	output logic flagInvert,
	output logic zeroResult,
	output logic [1:0] logicSel,
	output logic [1:0] widthMode
);

	logic srT;
	logic srS;

	assign srT = srIn[0];
	assign srS = srIn[1];

	assign widthMode = {opIxt[aluPkg::IxtQword], opIxt[aluPkg::IxtZext]};
	// qword together with zext means two independent dwords
	assign splitLanes = opIxt[aluPkg::IxtQword] & opIxt[aluPkg::IxtZext];

	always_comb begin
		adderInvert = 1'b0;
		carryLo = 1'b0;
		carryHi = 1'b0;
		useAdder = 1'b0;
		flagFromCarry = 1'b0;
		flagInvert = 1'b0;
		zeroResult = 1'b0;
		logicSel = aluPkg::LogicAnd;
		case (opIxt[3:0])
			aluPkg::OpAdd: begin
				useAdder = 1'b1;
			end
			aluPkg::OpSub: begin
				useAdder = 1'b1;
				adderInvert = 1'b1;
				carryLo = 1'b1;
				carryHi = 1'b1;
			end
			aluPkg::OpAdc: begin
				useAdder = 1'b1;
				carryLo = srT;
				carryHi = srS;
				flagFromCarry = 1'b1;
			end
			aluPkg::OpSbb: begin
				// borrow in is the inverted status bit
				useAdder = 1'b1;
				adderInvert = 1'b1;
				carryLo = ~srT;
				carryHi = ~srS;
				flagFromCarry = 1'b1;
				flagInvert = 1'b1;
			end
			aluPkg::OpAnd: logicSel = aluPkg::LogicAnd;
			aluPkg::OpOr: logicSel = aluPkg::LogicOr;
			aluPkg::OpXor: logicSel = aluPkg::LogicXor;
			aluPkg::OpCselt: logicSel = aluPkg::LogicCsel;
			// compare, test and nor slots
			default: zeroResult = 1'b1;
		endcase
	end

endmodule

/* design/carrySelectAdder.sv */
// ====================
// segmented carry-select adder, optional
// operand inversion, split at the dword
// ====================

module carrySelectAdder #(
	parameter int WordWidth = 64,
	parameter int LaneWidth = 32,
	parameter int SegWidth = 16
) (
	input logic [WordWidth-1:0] a,
	input logic [WordWidth-1:0] b,
	input logic invert,
	input logic carryLo,
	input logic carryHi,
	input logic splitLanes,
	output logic [WordWidth-1:0] sum,
	output logic carryLane,
	output logic carryOut
);

	localparam int NumSeg = WordWidth / SegWidth;
	// first segment of the upper lane
	localparam int LaneSeg = LaneWidth / SegWidth;

	logic [WordWidth-1:0] bIn;
	logic [NumSeg-1:0] segCarryIn;
	logic [NumSeg-1:0] segCarryOut;

	// subtract forms add the complement
	assign bIn = invert ? ~b : b;

	genvar i;
	generate
		for (i = 0; i < NumSeg; i++) begin : gSeg
			logic [SegWidth:0] sum0;
			logic [SegWidth:0] sum1;

			// both speculative sums, carry in 0 and 1
			assign sum0 = {1'b0, a[i*SegWidth +: SegWidth]}
				+ {1'b0, bIn[i*SegWidth +: SegWidth]};
			assign sum1 = {1'b0, a[i*SegWidth +: SegWidth]}
				+ {1'b0, bIn[i*SegWidth +: SegWidth]} + 1'b1;

			if (i == 0) begin : gFirst
				assign segCarryIn[i] = carryLo;
			end else if (i == LaneSeg) begin : gLane
				// upper dword takes its own carry when split
				assign segCarryIn[i] = splitLanes ? carryHi : segCarryOut[i-1];
			end else begin : gChain
				assign segCarryIn[i] = segCarryOut[i-1];
			end

			assign segCarryOut[i] = segCarryIn[i] ? sum1[SegWidth] : sum0[SegWidth];
			assign sum[i*SegWidth +: SegWidth] = segCarryIn[i]
				? sum1[SegWidth-1:0] : sum0[SegWidth-1:0];
		end
	endgenerate

	assign carryLane = segCarryOut[LaneSeg-1];
	assign carryOut = segCarryOut[NumSeg-1];

	// unsplit chain must match one wide addition
	always_comb begin
		assert final (splitLanes !== 1'b0 || $isunknown({a, b, invert, carryLo})
			|| {carryOut, sum} == ({1'b0, a} + {1'b0, bIn} + carryLo))
		else $error("carrySelectAdder: segment chain differs from wide sum");
	end

endmodule

/* design/aluLogicUnit.sv */
// ====================
// bitwise AND/OR/XOR and
// per-lane conditional select
// ====================

module aluLogicUnit #(
	parameter int WordWidth = 64,
	parameter int LaneWidth = 32
) (
	input logic [WordWidth-1:0] a,
	input logic [WordWidth-1:0] b,
	input logic [1:0] logicSel,
	input logic selLo,
	input logic selHi,
	output logic [WordWidth-1:0] logicVal
);

	logic [LaneWidth-1:0] cselLo;
	logic [WordWidth-LaneWidth-1:0] cselHi;

	// each lane picks a or b on its own bit
	assign cselLo = selLo ? a[LaneWidth-1:0] : b[LaneWidth-1:0];
	assign cselHi = selHi ? a[WordWidth-1:LaneWidth] : b[WordWidth-1:LaneWidth];

	always_comb begin
		case (logicSel)
			aluPkg::LogicAnd: logicVal = a & b;
			aluPkg::LogicOr: logicVal = a | b;
			aluPkg::LogicXor: logicVal = a ^ b;
			default: logicVal = {cselHi, cselLo};
		endcase
	end

endmodule

/* design/aluResultStage.sv */
// ====================
// result and flag select, width extension,
// hold-controlled output register
// ====================

module aluResultStage (
	input logic clock,
	input logic arstN,
	input logic hold,
	input logic [aluPkg::WordWidth-1:0] adderVal,
	input logic carryLane,
	input logic carryOut,
	input logic [aluPkg::WordWidth-1:0] logicVal,
	input logic useAdder,
	input logic flagFromCarry,
	input logic flagInvert,
	input logic zeroResult,
	input logic [1:0] widthMode,
	input logic [1:0] srIn,
	output aluPkg::aluWord_t valOut,
	output logic [1:0] srOut
);

	aluPkg::aluWord_t rawVal;
	aluPkg::aluWord_t nextVal;
	logic nextT;
	logic nextS;

	always_comb begin
		if (zeroResult) begin
			rawVal.full = '0;
		end else if (useAdder) begin
			rawVal.full = adderVal;
		end else begin
			rawVal.full = logicVal;
		end
	end

	// low lane always passes, upper lane depends on width
	always_comb begin
		nextVal.lane[0] = rawVal.lane[0];
		case (widthMode)
			aluPkg::Width32s:
				nextVal.lane[1] = {aluPkg::LaneWidth{rawVal.lane[0][aluPkg::LaneWidth-1]}};
			aluPkg::Width32u: nextVal.lane[1] = '0;
			default: nextVal.lane[1] = rawVal.lane[1];
		endcase
	end

	always_comb begin
		nextT = srIn[0];
		nextS = srIn[1];
		if (flagFromCarry) begin
			// borrow forms store the inverted carry
			if (widthMode == aluPkg::Width64) begin
				nextT = carryOut ^ flagInvert;
			end else begin
				nextT = carryLane ^ flagInvert;
			end
			if (widthMode == aluPkg::WidthPacked) begin
				nextS = carryOut ^ flagInvert;
			end
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			valOut <= '0;
			srOut <= '0;
		end else if (!hold) begin
			valOut <= nextVal;
			srOut <= {nextS, nextT};
		end
	end

	// a held edge leaves the outputs as they were
	heldOutputsStable: assert property (@(posedge clock) disable iff (!arstN)
		hold |=> ($stable(srOut) && $stable(valOut)))
	else $error("aluResultStage: outputs changed across a held edge");

endmodule

/* design/exAluLane.sv */
// ====================
// execute-stage ALU lane top:
// decoder, adder, logic unit, result register
// ====================

module exAluLane #(
	parameter int SegWidth = 16
) (
	input logic clock,
	input logic arstN,
	input logic [aluPkg::WordWidth-1:0] valRs,
	input logic [aluPkg::WordWidth-1:0] valRt,
	input logic [aluPkg::IxtWidth-1:0] opIxt,
	input logic hold,
	input logic [1:0] srIn,
	output aluPkg::aluWord_t valOut,
	output logic [1:0] srOut
);

	logic adderInvert;
	logic carryLo;
	logic carryHi;
	logic splitLanes;
	logic useAdder;
	logic flagFromCarry;
	logic flagInvert;
	logic zeroResult;
	logic [1:0] logicSel;
	logic [1:0] widthMode;
	logic [aluPkg::WordWidth-1:0] adderVal;
	logic carryLane;
	logic carryOut;
	logic [aluPkg::WordWidth-1:0] logicVal;
	logic selHi;

	// upper lane selects on S only in packed mode
	assign selHi = splitLanes ? srIn[1] : srIn[0];

	aluDecode i_aluDecode (
		.opIxt(opIxt),
		.srIn(srIn),
		.adderInvert(adderInvert),
		.carryLo(carryLo),
		.carryHi(carryHi),
		.splitLanes(splitLanes),
		.useAdder(useAdder),
		.flagFromCarry(flagFromCarry),
		.flagInvert(flagInvert),
		.zeroResult(zeroResult),
		.logicSel(logicSel),
		.widthMode(widthMode)
	);

	carrySelectAdder #(
		.WordWidth(aluPkg::WordWidth),
		.LaneWidth(aluPkg::LaneWidth),
		.SegWidth(SegWidth)
	) i_carrySelectAdder (
		.a(valRs),
		.b(valRt),
		.invert(adderInvert),
		.carryLo(carryLo),
		.carryHi(carryHi),
		.splitLanes(splitLanes),
		.sum(adderVal),
		.carryLane(carryLane),
		.carryOut(carryOut)
	);

	aluLogicUnit #(
		.WordWidth(aluPkg::WordWidth),
		.LaneWidth(aluPkg::LaneWidth)
	) i_aluLogicUnit (
		.a(valRs),
		.b(valRt),
		.logicSel(logicSel),
		.selLo(srIn[0]),
		.selHi(selHi),
		.logicVal(logicVal)
	);

	aluResultStage i_aluResultStage (
		.clock(clock),
		.arstN(arstN),
		.hold(hold),
		.adderVal(adderVal),
		.carryLane(carryLane),
		.carryOut(carryOut),
		.logicVal(logicVal),
		.useAdder(useAdder),
		.flagFromCarry(flagFromCarry),
		.flagInvert(flagInvert),
		.zeroResult(zeroResult),
		.widthMode(widthMode),
		.srIn(srIn),
		.valOut(valOut),
		.srOut(srOut)
	);

endmodule

/* tb/aluRefModel.svh */
// ====================
// reference model of one ALU operation,
// result word and T/S status bits
// ====================

`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// add/sub family on 65 bits, top bits hold carry or borrow
function automatic logic [64:0] laneArith(input logic [63:0] a, input logic [63:0] b,
	input logic [3:0] op, input logic c);
	logic [64:0] r;
	case (op)
		aluPkg::OpAdd: r = {1'b0, a} + {1'b0, b};
		aluPkg::OpSub: r = {1'b0, a} - {1'b0, b};
		aluPkg::OpAdc: r = {1'b0, a} + {1'b0, b} + {64'b0, c};
		default: r = {1'b0, a} - {1'b0, b} - {64'b0, c};
	endcase
	return r;
endfunction

function automatic void refModel(input logic [63:0] rs, input logic [63:0] rt,
	input logic [5:0] ixt, input logic [1:0] sr,
	output aluPkg::aluWord_t val, output logic [1:0] flags);
	logic [3:0] op;
	logic packedMode;
	logic isArith;
	logic isCarryOp;
	logic [64:0] wide;
	logic [64:0] lo;
	logic [64:0] hi;
	aluPkg::aluWord_t raw;
	op = ixt[3:0];
	packedMode = ixt[5] & ixt[4];
	isArith = (op == aluPkg::OpAdd) || (op == aluPkg::OpSub)
		|| (op == aluPkg::OpAdc) || (op == aluPkg::OpSbb);
	isCarryOp = (op == aluPkg::OpAdc) || (op == aluPkg::OpSbb);
	flags = sr;
	raw.full = '0;
	if (isArith) begin
		wide = laneArith(rs, rt, op, sr[0]);
		lo = laneArith({32'b0, rs[31:0]}, {32'b0, rt[31:0]}, op, sr[0]);
		// upper dword uses S as its own carry
		hi = laneArith({32'b0, rs[63:32]}, {32'b0, rt[63:32]}, op, sr[1]);
		if (packedMode) begin
			raw.lane[0] = lo[31:0];
			raw.lane[1] = hi[31:0];
			if (isCarryOp)
				flags = {hi[32], lo[32]};
		end else begin
			raw.full = wide[63:0];
			if (isCarryOp)
				flags[0] = ixt[5] ? wide[64] : lo[32];
		end
	end else begin
		case (op)
			aluPkg::OpAnd: raw.full = rs & rt;
			aluPkg::OpOr: raw.full = rs | rt;
			aluPkg::OpXor: raw.full = rs ^ rt;
			aluPkg::OpCselt: begin
				raw.lane[0] = sr[0] ? rs[31:0] : rt[31:0];
				raw.lane[1] = (packedMode ? sr[1] : sr[0]) ? rs[63:32] : rt[63:32];
			end
			default: raw.full = '0;
		endcase
	end
	case (ixt[5:4])
		2'b00: val.full = {{32{raw.lane[0][31]}}, raw.lane[0]};
		2'b01: val.full = {32'b0, raw.lane[0]};
		default: val = raw;
	endcase
endfunction

`endif

/* tb/tbExAluLane.sv */
// ====================
// testbench for the ALU lane: LFSR stimulus,
// reference model, hold and reset checks
// ====================

module tbExAluLane;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClockPeriod = 100;
	localparam int DriveDelay = 10;
	localparam int ResetCycles = 4;
	localparam int NumTests = 3000;

	logic clock;
	logic arstN;
	logic [63:0] valRs;
	logic [63:0] valRt;
	logic [5:0] opIxt;
	logic hold;
	logic [1:0] srIn;
	aluPkg::aluWord_t valOut;
	logic [1:0] srOut;

	logic [31:0] lfsrState = 32'h3583_bebe;
	aluPkg::aluWord_t expVal;
	logic [1:0] expSr;
	int testIndex;

	`include "aluRefModel.svh"

	exAluLane #(
		.SegWidth(16)
	) i_exAluLane (
		.clock(clock),
		.arstN(arstN),
		.valRs(valRs),
		.valRt(valRt),
		.opIxt(opIxt),
		.hold(hold),
		.srIn(srIn),
		.valOut(valOut),
		.srOut(srOut)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int count, output logic [63:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[62:0], lfsrState[0]};
		end
	endtask

	// kept codes weighted toward arithmetic, plus dropped slots 4, 9, 12
	function automatic logic [3:0] pickOp(input logic [3:0] idx);
		case (idx)
			4'd0, 4'd1: return aluPkg::OpAdd;
			4'd2, 4'd3: return aluPkg::OpSub;
			4'd4, 4'd5: return aluPkg::OpAdc;
			4'd6, 4'd7: return aluPkg::OpSbb;
			4'd8: return aluPkg::OpAnd;
			4'd9: return aluPkg::OpOr;
			4'd10: return aluPkg::OpXor;
			4'd11, 4'd12: return aluPkg::OpCselt;
			4'd13: return 4'd4;
			4'd14: return 4'd9;
			default: return 4'd12;
		endcase
	endfunction

	task automatic driveRandom(input logic forceHold);
		logic [63:0] opBits;
		logic [63:0] widthBits;
		logic [63:0] rsBits;
		logic [63:0] rtBits;
		logic [63:0] maskBits;
		logic [63:0] srBits;
		logic [63:0] holdBits;
		drawBits(4, opBits);
		drawBits(2, widthBits);
		drawBits(64, rsBits);
		drawBits(64, rtBits);
		drawBits(8, maskBits);
		drawBits(2, srBits);
		drawBits(3, holdBits);
		// ones in Rs and zeros in Rt make long carry and borrow chains
		for (int s = 0; s < 4; s++) begin
			if (maskBits[s])
				rsBits[s*16 +: 16] = '1;
			if (maskBits[s+4])
				rtBits[s*16 +: 16] = '0;
		end
		valRs = rsBits;
		valRt = rtBits;
		opIxt = {widthBits[1:0], pickOp(opBits[3:0])};
		srIn = srBits[1:0];
		hold = forceHold || (holdBits[2:0] == 3'd0);
	endtask

	task automatic checkWord(input string name, input aluPkg::aluWord_t got,
		input aluPkg::aluWord_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h (test %0d)",
				name, got.full, exp.full, testIndex);
			$display("*** TEST FAILED ***");
			$fatal(1, "result word mismatch");
		end
	endtask

	task automatic checkFlags(input string name, input logic [1:0] got,
		input logic [1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h (test %0d)",
				name, got, exp, testIndex);
			$display("*** TEST FAILED ***");
			$fatal(1, "status flag mismatch");
		end
	endtask

	initial begin
		#((ResetCycles + NumTests + 10) * ClockPeriod);
		$display("timeout: the run did not finish in the expected time");
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin
		aluPkg::aluWord_t pendVal;
		logic [1:0] pendSr;
		clock = 1'b0;
		arstN = 1'b0;
		hold = 1'b0;
		valRs = '0;
		valRt = '0;
		opIxt = '0;
		srIn = '0;
		expVal.full = '0;
		expSr = '0;
		testIndex = -1;
		repeat (ResetCycles) @(posedge clock);
		#DriveDelay;
		checkWord("valOut", valOut, expVal);
		checkFlags("srOut", srOut, expSr);
		arstN = 1'b1;
		// first edge after reset is held so the zero state must survive it
		for (testIndex = 0; testIndex < NumTests; testIndex++) begin
			driveRandom(testIndex == 0);
			if (hold) begin
				pendVal = expVal;
				pendSr = expSr;
			end else begin
				refModel(valRs, valRt, opIxt, srIn, pendVal, pendSr);
			end
			@(posedge clock);
			#DriveDelay;
			expVal = pendVal;
			expSr = pendSr;
			checkWord("valOut", valOut, expVal);
			checkFlags("srOut", srOut, expSr);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* exAluLane.f */
+incdir+tb
design/aluPkg.sv
design/aluDecode.sv
design/carrySelectAdder.sv
design/aluLogicUnit.sv
design/aluResultStage.sv
design/exAluLane.sv
tb/tbExAluLane.sv

/* Makefile */
# Verilator build, run, lint and clean for the ALU lane testbench

TOP = tbExAluLane

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f exAluLane.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing -Wall -f exAluLane.f --top-module $(TOP)

clean:
	rm -rf obj_dir
